/* hdl/displayPkg.sv */
package displayPkg;

  // ------------------------------
  // Panel geometry and timing
  // ------------------------------
  localparam int panelColumns    = 128;
  localparam int chipColumns     = 64;
  localparam int pageCount       = 8;
  localparam int lcdDivBits      = 8;
  localparam int framePauseTicks = 32768;

  // ------------------------------
  // LCD controller commands
  // ------------------------------
  localparam logic [7:0] cmdDisplayOn  = 8'h3F;
  localparam logic [7:0] cmdColumnZero = 8'h40;
  localparam logic [7:0] cmdStartLine  = 8'hC0;
  localparam logic [7:0] cmdPageBase   = 8'hB8;

  // Codes 0 to F match the nibbles of an expression word.
  typedef enum logic [4:0] {
    symDigit0, symDigit1, symDigit2, symDigit3, symDigit4,
    symDigit5, symDigit6, symDigit7, symDigit8, symDigit9,
    symPlus, symMinus, symTimes, symDivide,
    symBlankE, symBlankF,
    symLetterL, symLetterV, symLife
  } glyphSymbol;

  typedef enum logic [2:0] {
    stPowerUp,
    stStartLine,
    stColumnZero,
    stSetPage,
    stWriteColumns
  } seqState;

  typedef logic [8:0] lanePos;

  // Each glyph is 8 columns wide and two pages tall.
  // The first 8 bytes are the upper page, the last 8 the lower page.
  localparam logic [7:0] glyphTable [0:18][0:15] = '{
    '{8'h00, 8'hE0, 8'h18, 8'h08, 8'h08, 8'h18, 8'hE0, 8'h00,
      8'h00, 8'h03, 8'h0C, 8'h08, 8'h08, 8'h0C, 8'h03, 8'h00},
    '{8'h00, 8'h00, 8'h10, 8'h18, 8'hF8, 8'h00, 8'h00, 8'h00,
      8'h00, 8'h00, 8'h08, 8'h08, 8'h0F, 8'h08, 8'h08, 8'h00},
    '{8'h00, 8'h00, 8'h10, 8'h08, 8'h08, 8'h88, 8'h70, 8'h00,
      8'h00, 8'h00, 8'h0C, 8'h0E, 8'h0B, 8'h08, 8'h08, 8'h00},
    '{8'h00, 8'h00, 8'h10, 8'h88, 8'h88, 8'h88, 8'h70, 8'h00,
      8'h00, 8'h00, 8'h04, 8'h08, 8'h08, 8'h08, 8'h07, 8'h00},
    '{8'h00, 8'h00, 8'h80, 8'h60, 8'h18, 8'hF8, 8'h00, 8'h00,
      8'h00, 8'h03, 8'h02, 8'h02, 8'h02, 8'h0F, 8'h02, 8'h00},
    '{8'h00, 8'h00, 8'h78, 8'h48, 8'h48, 8'hC8, 8'h88, 8'h00,
      8'h00, 8'h00, 8'h04, 8'h08, 8'h08, 8'h0C, 8'h07, 8'h00},
    '{8'h00, 8'hE0, 8'h90, 8'h48, 8'h48, 8'hC8, 8'h00, 8'h00,
      8'h00, 8'h03, 8'h0C, 8'h08, 8'h08, 8'h0C, 8'h07, 8'h00},
    '{8'h00, 8'h00, 8'h08, 8'h08, 8'h88, 8'h68, 8'h18, 8'h00,
      8'h00, 8'h00, 8'h00, 8'h0C, 8'h03, 8'h00, 8'h00, 8'h00},
    '{8'h00, 8'h00, 8'h70, 8'h88, 8'h88, 8'h88, 8'h70, 8'h00,
      8'h00, 8'h00, 8'h07, 8'h08, 8'h08, 8'h08, 8'h07, 8'h00},
    '{8'h00, 8'h00, 8'hF0, 8'h08, 8'h08, 8'h18, 8'hF0, 8'h00,
      8'h00, 8'h00, 8'h08, 8'h09, 8'h09, 8'h05, 8'h03, 8'h00},
    '{8'h00, 8'h80, 8'h80, 8'hE0, 8'hE0, 8'h80, 8'h80, 8'h00,
      8'h00, 8'h01, 8'h01, 8'h07, 8'h07, 8'h01, 8'h01, 8'h00},
    '{8'h00, 8'h80, 8'h80, 8'h80, 8'h80, 8'h80, 8'h80, 8'h00,
      8'h00, 8'h01, 8'h01, 8'h01, 8'h01, 8'h01, 8'h01, 8'h00},
    '{8'h00, 8'h20, 8'h40, 8'h80, 8'h80, 8'h40, 8'h20, 8'h00,
      8'h00, 8'h04, 8'h02, 8'h01, 8'h01, 8'h02, 8'h04, 8'h00},
    '{8'h00, 8'h80, 8'h80, 8'hA0, 8'hA0, 8'h80, 8'h80, 8'h00,
      8'h00, 8'h01, 8'h01, 8'h05, 8'h05, 8'h01, 8'h01, 8'h00},
    '{default: 8'h00},
    '{default: 8'h00},
    '{8'h10, 8'hF0, 8'hF0, 8'h10, 8'h00, 8'h00, 8'h00, 8'h00,
      8'h00, 8'h0F, 8'h0F, 8'h0C, 8'h0C, 8'h0C, 8'h0E, 8'h00},
    '{8'h20, 8'hE0, 8'hE0, 8'h00, 8'h00, 8'hE0, 8'hE0, 8'h20,
      8'h00, 8'h00, 8'h03, 8'h0E, 8'h0E, 8'h03, 8'h00, 8'h00},
    '{8'hC0, 8'hE0, 8'hF0, 8'hE0, 8'hE0, 8'hF0, 8'hE0, 8'hC0,
      8'h01, 8'h03, 8'h07, 8'h0F, 8'h0F, 8'h07, 8'h03, 8'h01}
  };

endpackage

/* hdl/laneRenderer.sv */
`timescale 1ns/1ns

module laneRenderer (
  input  logic [2:0]         page,
  input  logic [6:0]         column,
  input  logic [11:0]        Exp1,
  input  logic [11:0]        Exp2,
  input  logic [11:0]        Exp3,
  input  logic [11:0]        Exp4,
  input  logic [11:0]        Exp5,
  input  logic [11:0]        Exp6,
  input  displayPkg::lanePos leadPos1,
  input  displayPkg::lanePos leadPos2,
  input  displayPkg::lanePos leadPos3,
  input  displayPkg::lanePos trailPos1,
  input  displayPkg::lanePos trailPos2,
  input  displayPkg::lanePos trailPos3,
  output logic [7:0]         laneByte
);

  import displayPkg::*;

  logic [11:0] leadExp;
  logic [11:0] trailExp;
  logic [11:0] expr;
  lanePos      leadPos;
  lanePos      trailPos;
  lanePos      colPos;
  lanePos      offset;
  logic        hit;
  glyphSymbol  sym;

  assign colPos = {2'b00, column};

  // Lane k sits on pages 2k and 2k+1.
  always_comb
  begin
    case (page[2:1])
      2'd1:    {leadExp, trailExp, leadPos, trailPos} = {Exp1, Exp4, leadPos1, trailPos1};
      2'd2:    {leadExp, trailExp, leadPos, trailPos} = {Exp2, Exp5, leadPos2, trailPos2};
      2'd3:    {leadExp, trailExp, leadPos, trailPos} = {Exp3, Exp6, leadPos3, trailPos3};
      default: {leadExp, trailExp, leadPos, trailPos} = '0;
    endcase
  end

  always_comb
  begin
    hit    = 1'b0;
    expr   = leadExp;
    offset = '0;
    if (colPos > leadPos && colPos < leadPos + 9'd24)
    begin
      hit    = 1'b1;
      offset = colPos - leadPos;
    end
    else if (colPos > trailPos && colPos < trailPos + 9'd24)
    begin
      hit    = 1'b1;
      expr   = trailExp;
      offset = colPos - trailPos;
    end
    case (offset[4:3])
      2'd0:    sym = glyphSymbol'({1'b0, expr[11:8]});
      2'd1:    sym = glyphSymbol'({1'b0, expr[7:4]});
      default: sym = glyphSymbol'({1'b0, expr[3:0]});
    endcase
  end

  assign laneByte = (hit && page[2:1] != 2'd0) ? glyphTable[sym][{page[0], offset[2:0]}] : 8'h00;

endmodule

/* hdl/laneScroller.sv */
`timescale 1ns/1ns

module laneScroller (
  input  logic               CLK,
  input  logic               RESET,
  input  logic               frameDone,
  output displayPkg::lanePos leadPos1,
  output displayPkg::lanePos leadPos2,
  output displayPkg::lanePos leadPos3,
  output displayPkg::lanePos trailPos1,
  output displayPkg::lanePos trailPos2,
  output displayPkg::lanePos trailPos3,
  output logic               Update
);

  import displayPkg::*;

  logic leadPastChip;

  // A lead that has left the left chip ends the current round.
  assign leadPastChip = (leadPos1 >= lanePos'(chipColumns)) ||
                        (leadPos2 >= lanePos'(chipColumns)) ||
                        (leadPos3 >= lanePos'(chipColumns));

  always_ff @(posedge CLK or negedge RESET)
  begin
    if (!RESET)
    begin
      leadPos1  <= '0;
      leadPos2  <= '0;
      leadPos3  <= '0;
      trailPos1 <= lanePos'(chipColumns);
      trailPos2 <= lanePos'(chipColumns);
      trailPos3 <= lanePos'(chipColumns);
      Update    <= 1'b0;
    end
    else
    begin
      Update <= 1'b0;
      if (frameDone && leadPastChip)
      begin
        Update    <= 1'b1;
        trailPos1 <= leadPos1;
        trailPos2 <= leadPos2;
        trailPos3 <= leadPos3;
        leadPos1  <= '0;
        leadPos2  <= '0;
        leadPos3  <= '0;
      end
      else if (frameDone)
      begin
        leadPos1  <= leadPos1 + 9'd1;
        leadPos2  <= leadPos2 + 9'd1;
        leadPos3  <= leadPos3 + 9'd1;
        trailPos1 <= trailPos1 + 9'd1;
        trailPos2 <= trailPos2 + 9'd1;
        trailPos3 <= trailPos3 + 9'd1;
      end
    end
  end

endmodule

/* hdl/lcdDisplay.sv */
`timescale 1ns/1ns

module lcdDisplay #(
  parameter int clkDivBits = displayPkg::lcdDivBits,
  parameter int pauseTicks = displayPkg::framePauseTicks
) (
  input  logic        CLK,
  input  logic        RESET,
  input  logic [11:0] Exp1,
  input  logic [11:0] Exp2,
  input  logic [11:0] Exp3,
  input  logic [11:0] Exp4,
  input  logic [11:0] Exp5,
  input  logic [11:0] Exp6,
  input  logic [6:0]  Score,
  input  logic [1:0]  Life,
  output logic        LcdEnable,
  output logic        LcdRw,
  output logic        LcdDi,
  output logic        LcdCs1,
  output logic        LcdCs2,
  output logic        LcdRst,
  output logic [7:0]  LcdData,
  output logic        Update
);

  import displayPkg::*;

  logic [2:0] page;
  logic [6:0] column;
  logic [7:0] statusByte;
  logic [7:0] laneByte;
  logic       frameDone;
  lanePos     leadPos1;
  lanePos     leadPos2;
  lanePos     leadPos3;
  lanePos     trailPos1;
  lanePos     trailPos2;
  lanePos     trailPos3;

  lcdSequencer #(
    .clkDivBits(clkDivBits),
    .pauseTicks(pauseTicks)
  ) lcdSequencer_i (
    .CLK(CLK), .RESET(RESET),
    .statusByte(statusByte), .laneByte(laneByte),
    .page(page), .column(column), .frameDone(frameDone),
    .LcdEnable(LcdEnable), .LcdRw(LcdRw), .LcdDi(LcdDi),
    .LcdCs1(LcdCs1), .LcdCs2(LcdCs2), .LcdRst(LcdRst), .LcdData(LcdData)
  );

  laneScroller laneScroller_i (
    .CLK(CLK), .RESET(RESET), .frameDone(frameDone),
    .leadPos1(leadPos1), .leadPos2(leadPos2), .leadPos3(leadPos3),
    .trailPos1(trailPos1), .trailPos2(trailPos2), .trailPos3(trailPos3),
    .Update(Update)
  );

  statusRenderer statusRenderer_i (
    .page(page), .column(column), .Score(Score), .Life(Life),
    .statusByte(statusByte)
  );

  laneRenderer laneRenderer_i (
    .page(page), .column(column),
    .Exp1(Exp1), .Exp2(Exp2), .Exp3(Exp3), .Exp4(Exp4), .Exp5(Exp5), .Exp6(Exp6),
    .leadPos1(leadPos1), .leadPos2(leadPos2), .leadPos3(leadPos3),
    .trailPos1(trailPos1), .trailPos2(trailPos2), .trailPos3(trailPos3),
    .laneByte(laneByte)
  );

endmodule

/* hdl/lcdSequencer.sv */
`timescale 1ns/1ns

module lcdSequencer #(
  parameter int clkDivBits = displayPkg::lcdDivBits,
  parameter int pauseTicks = displayPkg::framePauseTicks
) (
  input  logic       CLK,
  input  logic       RESET,
  input  logic [7:0] statusByte,
  input  logic [7:0] laneByte,
  output logic [2:0] page,
  output logic [6:0] column,
  output logic       frameDone,
  output logic       LcdEnable,
  output logic       LcdRw,
  output logic       LcdDi,
  output logic       LcdCs1,
  output logic       LcdCs2,
  output logic       LcdRst,
  output logic [7:0] LcdData
);

  import displayPkg::*;

  localparam int pauseBits = $clog2(pauseTicks + 2);

  logic [clkDivBits-1:0] divCount;
  logic                  tick;
  logic [1:0]            busPhase;
  logic [pauseBits-1:0]  pauseCount;
  logic [7:0]            writeCount;
  logic                  clearing;
  logic [1:0]            chipSel;
  seqState               state;

  // ------------------------------
  // Tick enable
  // ------------------------------
  always_ff @(posedge CLK or negedge RESET)
  begin
    if (!RESET)
      divCount <= '0;
    else
      divCount <= divCount + 1'b1;
  end

  assign tick = &divCount;

  // Phase 0 is setup, 1 holds the strobe high, 2 is the low half and idle.
  assign LcdEnable = (busPhase == 2'd1);
  assign LcdRw     = 1'b0;
  assign LcdCs1    = chipSel[0];
  assign LcdCs2    = chipSel[1];
  assign column    = writeCount[6:0];

  // ------------------------------
  // Command and data sequencing
  // ------------------------------
  always_ff @(posedge CLK or negedge RESET)
  begin
    if (!RESET)
    begin
      state      <= stPowerUp;
      page       <= 3'd0;
      writeCount <= 8'd0;
      clearing   <= 1'b1;
      busPhase   <= 2'd2;
      pauseCount <= '0;
      chipSel    <= 2'b11;
      LcdDi      <= 1'b0;
      LcdRst     <= 1'b0;
      LcdData    <= 8'h00;
      frameDone  <= 1'b0;
    end
    else
    begin
      frameDone <= 1'b0;
      if (tick)
      begin
        if (busPhase != 2'd2)
          busPhase <= busPhase + 2'd1;
        else if (pauseCount != '0)
          pauseCount <= pauseCount - 1'b1;
        else
        begin
          case (state)
            stPowerUp:
            begin
              LcdRst   <= 1'b1;
              LcdData  <= cmdDisplayOn;
              busPhase <= 2'd0;
              state    <= stColumnZero;
            end
            stColumnZero:
            begin
              LcdData  <= cmdColumnZero;
              busPhase <= 2'd0;
              state    <= stStartLine;
            end
            stStartLine:
            begin
              LcdData  <= cmdStartLine;
              busPhase <= 2'd0;
              state    <= stSetPage;
            end
            stSetPage:
            begin
              LcdDi      <= 1'b0;
              chipSel    <= 2'b11;
              LcdData    <= cmdPageBase + {5'd0, page};
              writeCount <= 8'd0;
              busPhase   <= 2'd0;
              state      <= stWriteColumns;
            end
            default:
            begin
              if (clearing && writeCount < 8'(chipColumns))
              begin
                LcdDi      <= 1'b1;
                LcdData    <= 8'h00;
                writeCount <= writeCount + 8'd1;
                busPhase   <= 2'd0;
              end
              else if (!clearing && writeCount < 8'(panelColumns))
              begin
                LcdDi      <= 1'b1;
                LcdData    <= (page < 3'd2) ? statusByte : laneByte;
                chipSel    <= writeCount[6] ? 2'b10 : 2'b01;
                writeCount <= writeCount + 8'd1;
                busPhase   <= 2'd0;
              end
              else
              begin
                state <= stSetPage;
                page  <= page + 3'd1;
                if (page == 3'(pageCount - 1))
                begin
                  // End of a full pass over the panel.
                  clearing <= 1'b0;
                  if (!clearing)
                  begin
                    frameDone  <= 1'b1;
                    pauseCount <= pauseBits'(pauseTicks);
                  end
                end
              end
            end
          endcase
        end
      end
    end
  end

endmodule

/* hdl/statusRenderer.sv */
`timescale 1ns/1ns

module statusRenderer (
  input  logic [2:0] page,
  input  logic [6:0] column,
  input  logic [6:0] Score,
  input  logic [1:0] Life,
  output logic [7:0] statusByte
);

  import displayPkg::*;

  logic [3:0] level;
  logic [7:0] lifeEnd;
  glyphSymbol sym;

  assign level   = 4'(Score / 7'd10 + 7'd1);
  assign lifeEnd = 8'd96 + {3'd0, Life, 3'd0};

  // Every cell starts on a multiple of 8, so column[2:0] is the glyph column.
  always_comb
  begin
    sym = symBlankE;
    if (column < 7'd8)
      sym = symLetterL;
    else if (column < 7'd16)
      sym = symLetterV;
    else if (column >= 7'd24 && column < 7'd32)
    begin
      if (level <= 4'd9)
        sym = glyphSymbol'({1'b0, level});
    end
    else if (column >= 7'd96 && {1'b0, column} < lifeEnd)
      sym = symLife;
  end

  // Page 0 carries the upper half of the row, page 1 the lower half.
  assign statusByte = (page < 3'd2) ? glyphTable[sym][{page[0], column[2:0]}] : 8'h00;

endmodule

/* testbench/lcdDisplayTb.sv */
`timescale 1ns/1ns

module lcdDisplayTb;

  import displayPkg::*;

  logic        CLK;
  logic        RESET;
  logic [11:0] Exp1;
  logic [11:0] Exp2;
  logic [11:0] Exp3;
  logic [11:0] Exp4;
  logic [11:0] Exp5;
  logic [11:0] Exp6;
  logic [6:0]  Score;
  logic [1:0]  Life;
  logic        LcdEnable;
  logic        LcdRw;
  logic        LcdDi;
  logic        LcdCs1;
  logic        LcdCs2;
  logic        LcdRst;
  logic [7:0]  LcdData;
  logic        Update;
  int          seed;
  int          seenTransfers;
  int          expectedUpdates;
  int          leadCol;
  int          trailCol;
  int          updateSeen = 0;

  lcdDisplay #(
    .clkDivBits(2),
    .pauseTicks(4)
  ) lcdDisplay_i (
    .CLK(CLK), .RESET(RESET),
    .Exp1(Exp1), .Exp2(Exp2), .Exp3(Exp3), .Exp4(Exp4), .Exp5(Exp5), .Exp6(Exp6),
    .Score(Score), .Life(Life),
    .LcdEnable(LcdEnable), .LcdRw(LcdRw), .LcdDi(LcdDi),
    .LcdCs1(LcdCs1), .LcdCs2(LcdCs2), .LcdRst(LcdRst), .LcdData(LcdData),
    .Update(Update)
  );

  lcdPanelModel panel (
    .LcdEnable(LcdEnable), .LcdDi(LcdDi), .LcdCs1(LcdCs1), .LcdCs2(LcdCs2),
    .LcdRst(LcdRst), .LcdData(LcdData)
  );

  initial
  begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  always @(posedge CLK)
  begin
    if (Update === 1'b1)
      updateSeen <= updateSeen + 1;
  end

  // ------------------------------
  // Reporting and waiting
  // ------------------------------
  task automatic failRun(input string reason);
    $display("tests failed");
    $display("%s", reason);
    $fatal(1);
  endtask

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    assert (actual === expected)
    else
      failRun($sformatf("ERR %s expected %0h actual %0h", name, expected, actual));
  endtask

  task automatic awaitTransfer();
    int waited;
    waited = 0;
    while (panel.transferCount == seenTransfers && waited < 400)
    begin
      @(posedge CLK);
      waited++;
    end
    if (panel.transferCount == seenTransfers)
      failRun("no LCD transfer arrived within 400 clocks");
    else
      seenTransfers++;
  endtask

  task automatic expectTransfer(input string name, input logic di, input logic cs1,
                                input logic cs2, input logic [7:0] data, input bit checkData);
    awaitTransfer();
    checkValue({name, " LcdRst"}, 1, panel.lastRst);
    checkValue({name, " LcdRw"}, 0, LcdRw);
    checkValue({name, " LcdDi"}, di, panel.lastDi);
    checkValue({name, " LcdCs1"}, cs1, panel.lastCs1);
    checkValue({name, " LcdCs2"}, cs2, panel.lastCs2);
    if (checkData)
      checkValue({name, " LcdData"}, data, panel.lastData);
  endtask

  task automatic awaitUpdate();
    int waited;
    waited = 0;
    while (Update !== 1'b1 && waited < 100)
    begin
      @(posedge CLK);
      waited++;
    end
    if (Update !== 1'b1)
      failRun("Update did not pulse after the lead expressions passed the left chip");
    else
    begin
      @(posedge CLK);
      checkValue("update width", 0, Update);
    end
  endtask

  // ------------------------------
  // Stimulus and expected image
  // ------------------------------
  function automatic logic [11:0] randomExpr();
    logic [11:0] e;
    for (int i = 0; i < 3; i++)
      e[4 * i +: 4] = 4'($unsigned($random(seed)) % 14);
    return e;
  endfunction

  task automatic randomizeInputs();
    Score <= 7'($unsigned($random(seed)) % 90);
    Life  <= 2'($random(seed));
    Exp1  <= randomExpr();
    Exp2  <= randomExpr();
    Exp3  <= randomExpr();
    Exp4  <= randomExpr();
    Exp5  <= randomExpr();
    Exp6  <= randomExpr();
  endtask

  function automatic logic [7:0] statusExpected(input int p, input int c);
    int sym;
    int level;
    level = int'(Score) / 10 + 1;
    sym = symBlankE;
    if (c < 8)
      sym = symLetterL;
    else if (c < 16)
      sym = symLetterV;
    else if (c >= 24 && c < 32)
    begin
      if (level <= 9)
        sym = level;
    end
    else if (c >= 96 && c < 96 + 8 * int'(Life))
      sym = symLife;
    return glyphTable[sym][p * 8 + c % 8];
  endfunction

  // A column belongs to an expression strictly after its position and before position + 24.
  function automatic logic [7:0] laneExpected(input int p, input int c,
                                              input logic [11:0] leadExp,
                                              input logic [11:0] trailExp);
    int offset;
    logic [11:0] e;
    if (c > leadCol && c < leadCol + 24)
    begin
      offset = c - leadCol;
      e = leadExp;
    end
    else if (c > trailCol && c < trailCol + 24)
    begin
      offset = c - trailCol;
      e = trailExp;
    end
    else
      return 8'h00;
    return glyphTable[e[4 * (2 - offset / 8) +: 4]][(p % 2) * 8 + offset % 8];
  endfunction

  task automatic checkFrame();
    logic [11:0] leadExp;
    logic [11:0] trailExp;
    for (int p = 0; p < pageCount; p++)
    begin
      {leadExp, trailExp} = (p < 4) ? {Exp1, Exp4} : (p < 6) ? {Exp2, Exp5} : {Exp3, Exp6};
      for (int c = 0; c < panelColumns; c++)
      begin
        if (p < 2)
          checkValue($sformatf("status p%0d c%0d", p, c), statusExpected(p, c),
                     panel.image[p][c]);
        else
          checkValue($sformatf("lanes p%0d c%0d", p, c),
                     laneExpected(p, c, leadExp, trailExp), panel.image[p][c]);
      end
    end
  endtask

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial
  begin
    seed = 55401;
    RESET = 1'b0;
    seenTransfers = 0;
    expectedUpdates = 0;
    leadCol = 0;
    trailCol = chipColumns;
    randomizeInputs();
    repeat (10) @(posedge CLK);
    checkValue("reset LcdEnable", 0, LcdEnable);
    checkValue("reset LcdRst", 0, LcdRst);
    checkValue("reset LcdDi", 0, LcdDi);
    checkValue("reset LcdRw", 0, LcdRw);
    checkValue("reset LcdCs1", 1, LcdCs1);
    checkValue("reset LcdCs2", 1, LcdCs2);
    RESET <= 1'b1;

    expectTransfer("startup display on", 0, 1, 1, cmdDisplayOn, 1);
    expectTransfer("startup column zero", 0, 1, 1, cmdColumnZero, 1);
    expectTransfer("startup start line", 0, 1, 1, cmdStartLine, 1);

    for (int p = 0; p < pageCount; p++)
    begin
      expectTransfer("clear page", 0, 1, 1, 8'(cmdPageBase + p), 1);
      repeat (chipColumns) expectTransfer("clear data", 1, 1, 1, 8'h00, 1);
    end

    // Frame 64 carries the leads past the left chip, frame 65 shows the hand-over.
    for (int frame = 0; frame <= chipColumns + 1; frame++)
    begin
      for (int p = 0; p < pageCount; p++)
      begin
        expectTransfer("refresh page", 0, 1, 1, 8'(cmdPageBase + p), 1);
        for (int c = 0; c < panelColumns; c++)
          expectTransfer("chip select", 1, c < chipColumns, c >= chipColumns, 8'h00, 0);
      end
      checkValue("frame count", frame + 1, panel.frameCount);
      checkFrame();
      if (leadCol >= chipColumns)
      begin
        awaitUpdate();
        expectedUpdates++;
        trailCol = leadCol;
        leadCol = 0;
      end
      else
      begin
        leadCol++;
        trailCol++;
      end
      checkValue("update count", expectedUpdates, updateSeen);
      randomizeInputs();
    end

    $display("all tests passed");
    $finish;
  end

endmodule

/* testbench/lcdPanelModel.sv */
`timescale 1ns/1ns

module lcdPanelModel (
  input logic       LcdEnable,
  input logic       LcdDi,
  input logic       LcdCs1,
  input logic       LcdCs2,
  input logic       LcdRst,
  input logic [7:0] LcdData
);

  import displayPkg::*;

  logic [7:0] image [0:pageCount-1][0:panelColumns-1];
  logic [2:0] page1;
  logic [2:0] page2;
  logic [5:0] col1;
  logic [5:0] col2;
  logic [7:0] lastData;
  logic       lastDi;
  logic       lastCs1;
  logic       lastCs2;
  logic       lastRst;
  logic       strobed = 1'b0;
  int         transferCount = 0;
  int         frameCount = 0;

  // A falling edge is a transfer only after the strobe has actually been high.
  always @(posedge LcdEnable)
  begin
    strobed = 1'b1;
  end

  // The panel latches on the falling edge of the strobe and ignores the bus while in reset.
  always @(negedge LcdEnable)
  begin
    if (strobed)
    begin
      strobed  = 1'b0;
      lastRst  = LcdRst;
      lastData = LcdData;
      lastDi   = LcdDi;
      lastCs1  = LcdCs1;
      lastCs2  = LcdCs2;
      if (LcdRst === 1'b1)
      begin
        if (!LcdDi && LcdData[7:6] == 2'b01)
        begin
          if (LcdCs1)
            col1 = LcdData[5:0];
          if (LcdCs2)
            col2 = LcdData[5:0];
        end
        else if (!LcdDi && LcdData[7:3] == 5'b10111)
        begin
          if (LcdCs1)
            page1 = LcdData[2:0];
          if (LcdCs2)
            page2 = LcdData[2:0];
        end
        else if (LcdDi)
        begin
          if (LcdCs1)
          begin
            image[page1][{1'b0, col1}] = LcdData;
            col1 = col1 + 6'd1;
          end
          if (LcdCs2)
          begin
            // The right chip alone on the last byte of page 7 closes a refresh frame.
            if (!LcdCs1 && page2 == 3'd7 && col2 == 6'd63)
              frameCount = frameCount + 1;
            image[page2][{1'b1, col2}] = LcdData;
            col2 = col2 + 6'd1;
          end
        end
      end
      transferCount = transferCount + 1;
    end
  end

endmodule

/* verilog.f */
hdl/displayPkg.sv
hdl/lcdSequencer.sv
hdl/laneScroller.sv
hdl/statusRenderer.sv
hdl/laneRenderer.sv
hdl/lcdDisplay.sv
testbench/lcdPanelModel.sv
testbench/lcdDisplayTb.sv
